//--- include/ft_bridge_macros.svh
`ifndef FT_BRIDGE_MACROS_SVH
`define FT_BRIDGE_MACROS_SVH

// bus word and byte enables
`define FT_DATA_W 32
`define FT_BE_W 4

// default FIFO depth as log2
`define FT_FIFO_DEPTH_LOG2 4

// covers the beats still in flight after rd_n rises
`define FT_AFULL_SLACK 3

`endif

//--- design/ft_bus_pkg.sv
`default_nettype none

`include "ft_bridge_macros.svh"

package ft_bus_pkg;

    typedef logic [`FT_DATA_W-1:0] ft_data_t;
    typedef logic [`FT_BE_W-1:0]   ft_be_t;

    // driven by the bridge, bus_oe enables the data and be pins
    typedef struct packed {
        ft_data_t data_out;
        ft_be_t   be_out;
        logic     bus_oe;
        logic     oe_n;
        logic     rd_n;
        logic     wr_n;
    } ft_pins_out_t;

    // driven by the device
    typedef struct packed {
        ft_data_t data_in;
        ft_be_t   be_in;
        logic     rxf_n;
        logic     txe_n;
    } ft_pins_in_t;

    typedef enum logic [1:0] {IDLE, WRITE, READ_TURN, READ} ft_bus_state_e;

endpackage

`default_nettype wire

//--- design/ft_user_pkg.sv
`default_nettype none

`include "ft_bridge_macros.svh"

package ft_user_pkg;

    import ft_bus_pkg::*;

    // one user word, data in the upper bits
    typedef struct packed {
        ft_data_t data;
        ft_be_t   be;
    } user_word_t;

    // occupancy, one extra bit so that full fits
    typedef logic [`FT_FIFO_DEPTH_LOG2:0] fifo_level_t;

endpackage

`default_nettype wire

//--- design/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "ft_bridge_macros.svh"

module sync_fifo
    import ft_user_pkg::*;
#(
    parameter int DEPTH_LOG2 = `FT_FIFO_DEPTH_LOG2
) (
    input  logic       clk,
    input  logic       reset_n,
    input  user_word_t in_word,
    input  logic       in_valid,
    output logic       in_ready,
    output user_word_t out_word,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       afull
);

    localparam int          ENTRIES     = 2 ** DEPTH_LOG2;
    localparam fifo_level_t DEPTH       = fifo_level_t'(ENTRIES);
    localparam fifo_level_t AFULL_LEVEL = DEPTH - fifo_level_t'(`FT_AFULL_SLACK);

    user_word_t            mem [ENTRIES];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    fifo_level_t           count;
    logic                  push;
    logic                  pop;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // show-ahead, head of queue always on the output
    assign out_word = mem[rd_ptr];

    // fewer than the slack entries left
    assign afull = (count > AFULL_LEVEL);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a full FIFO has its write side wrapped round onto the read side
    a_full_ptrs: assert property (
        @(posedge clk) disable iff (!reset_n)
        (count == DEPTH) |-> (wr_ptr == rd_ptr)
    );

    // an empty FIFO has read back everything that was written
    a_empty_ptrs: assert property (
        @(posedge clk) disable iff (!reset_n)
        (count == '0) |-> (wr_ptr == rd_ptr)
    );

endmodule

`default_nettype wire

//--- design/ft_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ft_bus_ctrl
    import ft_bus_pkg::*;
    import ft_user_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  user_word_t   tx_word,
    input  logic         tx_valid,
    output logic         tx_pop,
    output user_word_t   rx_word,
    output logic         rx_push,
    input  logic         rx_afull,
    input  ft_pins_in_t  bus_in,
    output ft_pins_out_t bus_out
);

    ft_bus_state_e state;
    logic          oe_n_q;
    logic          rd_n_q;
    // set when the last burst was a read
    logic          last_read;
    logic          read_req;
    logic          write_req;
    logic          read_beat;
    logic          read_stop;

    // device has data and the receive side has room
    assign read_req  = !bus_in.rxf_n && !rx_afull;
    // a word is waiting and the device can take it
    assign write_req = tx_valid && !bus_in.txe_n;

    // one word per edge with oe_n, rd_n and rxf_n all low
    assign read_beat = (state == READ) && !oe_n_q && !rd_n_q && !bus_in.rxf_n;
    assign read_stop = bus_in.rxf_n || rx_afull;

    // accepted write beat, wr_n low and txe_n low
    assign tx_pop = (state == WRITE) && tx_valid && !bus_in.txe_n;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= IDLE;
            oe_n_q    <= 1'b1;
            rd_n_q    <= 1'b1;
            last_read <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // releases oe_n one cycle after rd_n went high
                    oe_n_q <= 1'b1;
                    // no new burst until the turnaround is over
                    if (oe_n_q) begin
                        if (read_req && (!write_req || !last_read)) begin
                            state     <= READ_TURN;
                            oe_n_q    <= 1'b0;
                            last_read <= 1'b1;
                        end else if (write_req) begin
                            state     <= WRITE;
                            last_read <= 1'b0;
                        end
                    end
                end

                READ_TURN: begin
                    // oe_n has been low for a cycle, now start strobing
                    if (read_req) begin
                        state  <= READ;
                        rd_n_q <= 1'b0;
                    end else begin
                        state <= IDLE;
                    end
                end

                READ: begin
                    if (read_stop) begin
                        state  <= IDLE;
                        rd_n_q <= 1'b1;
                    end
                end

                WRITE: begin
                    // transmit FIFO empty or device full
                    if (!write_req) begin
                        state <= IDLE;
                    end
                end

                default: begin
                    state  <= IDLE;
                    oe_n_q <= 1'b1;
                    rd_n_q <= 1'b1;
                end
            endcase
        end
    end

    // capture of read beats into the receive path
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rx_push <= 1'b0;
        end else begin
            rx_push <= read_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (read_beat) begin
            rx_word.data <= bus_in.data_in;
            rx_word.be   <= bus_in.be_in;
        end
    end

    // head of the transmit FIFO goes straight onto the pins
    always_comb begin
        bus_out.data_out = tx_word.data;
        bus_out.be_out   = tx_word.be;
        bus_out.bus_oe   = (state == WRITE);
        bus_out.oe_n     = oe_n_q;
        bus_out.rd_n     = rd_n_q;
        bus_out.wr_n     = !((state == WRITE) && tx_valid);
    end

    // the two directions never strobe together
    a_no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(!bus_out.wr_n && !bus_out.rd_n)
    );

    // no contention, the device drives the pins while oe_n is low
    a_no_drive_while_oe: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(bus_out.bus_oe && !bus_out.oe_n)
    );

    // turnaround: rd_n only falls after oe_n was already low
    a_read_turnaround: assert property (
        @(posedge clk) disable iff (!reset_n)
        $fell(bus_out.rd_n) |-> $past(!bus_out.oe_n)
    );

endmodule

`default_nettype wire

//--- design/ft601_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "ft_bridge_macros.svh"

module ft601_bridge
    import ft_bus_pkg::*;
    import ft_user_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,

    // user write side
    input  user_word_t   wr_word,
    input  logic         wr_valid,
    output logic         wr_ready,

    // user read side
    output user_word_t   rd_word,
    output logic         rd_valid,
    input  logic         rd_ready,

    // FT601 bus
    input  ft_pins_in_t  bus_in,
    output ft_pins_out_t bus_out
);

    // transmit FIFO to controller
    user_word_t tx_word;
    logic       tx_valid;
    logic       tx_pop;

    // controller to receive FIFO
    user_word_t rx_word;
    logic       rx_push;
    logic       rx_afull;

    // user words waiting for the bus
    sync_fifo #(
        .DEPTH_LOG2 (`FT_FIFO_DEPTH_LOG2)
    ) i_tx_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_word   (wr_word),
        .in_valid  (wr_valid),
        .in_ready  (wr_ready),
        .out_word  (tx_word),
        .out_valid (tx_valid),
        .out_ready (tx_pop),
        .afull     ()
    );

    ft_bus_ctrl i_bus_ctrl (
        .clk      (clk),
        .reset_n  (reset_n),
        .tx_word  (tx_word),
        .tx_valid (tx_valid),
        .tx_pop   (tx_pop),
        .rx_word  (rx_word),
        .rx_push  (rx_push),
        .rx_afull (rx_afull),
        .bus_in   (bus_in),
        .bus_out  (bus_out)
    );

    // bus words waiting for the user
    // in_ready is left open, rx_afull keeps the controller from overrunning it
    sync_fifo #(
        .DEPTH_LOG2 (`FT_FIFO_DEPTH_LOG2)
    ) i_rx_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_word   (rx_word),
        .in_valid  (rx_push),
        .in_ready  (),
        .out_word  (rd_word),
        .out_valid (rd_valid),
        .out_ready (rd_ready),
        .afull     (rx_afull)
    );

endmodule

`default_nettype wire

//--- test/ft601_model.sv
`timescale 1ns/1ps
`default_nettype none

module ft601_model
    import ft_bus_pkg::*;
    import ft_user_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  ft_pins_out_t bus_out,
    output ft_pins_in_t  bus_in,
    output int           read_beats,
    output logic         bus_error
);

    // device idle until the first falling edge
    ft_pins_in_t pins = '{data_in: '0, be_in: '0, rxf_n: 1'b1, txe_n: 1'b1};
    int          beats = 0;
    logic        error_seen = 1'b0;

    // written words wait here until the bridge reads them back
    user_word_t  loop_q [$];

    assign bus_in     = pins;
    assign read_beats = beats;
    assign bus_error  = error_seen;

    task automatic report_violation(input string what);
        $display("bus protocol error at %0t: %s", $time, what);
        error_seen = 1'b1;
    endtask

    // pins change on the falling edge, beats land on the next rising edge
    always @(negedge clk) begin
        user_word_t head;
        user_word_t got;
        if (!reset_n) begin
            loop_q.delete();
            pins.rxf_n = 1'b1;
            pins.txe_n = 1'b1;
        end else begin
            if (!bus_out.wr_n && !bus_out.rd_n) begin
                report_violation("wr_n and rd_n low in the same cycle");
            end
            if (!bus_out.rd_n && bus_out.oe_n) begin
                report_violation("rd_n low while oe_n is high");
            end
            if (bus_out.bus_oe && !bus_out.oe_n) begin
                report_violation("bridge drives data while oe_n is low");
            end

            // device full roughly one cycle in four
            pins.txe_n = (($urandom % 4) == 0);
            pins.rxf_n = (loop_q.size() == 0);
            head = pins.rxf_n ? '0 : loop_q[0];
            pins.data_in = head.data;
            pins.be_in   = head.be;

            // write beat
            if (!bus_out.wr_n && !pins.txe_n) begin
                got.data = bus_out.data_out;
                got.be   = bus_out.be_out;
                loop_q.push_back(got);
            end
            // read beat, head leaves the queue
            if (!bus_out.oe_n && !bus_out.rd_n && !pins.rxf_n) begin
                void'(loop_q.pop_front());
                beats++;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_ft601_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "ft_bridge_macros.svh"

module tb_ft601_bridge
    import ft_bus_pkg::*;
    import ft_user_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int N_ROWS          = 24;
    localparam int HOLD_CYCLES     = 60;
    localparam int DRAIN_CYCLES    = 20;
    localparam int CYCLES_PER_WORD = 16;
    localparam int RX_DEPTH        = 2 ** `FT_FIFO_DEPTH_LOG2;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + N_ROWS * CYCLES_PER_WORD
                                     + 2 * HOLD_CYCLES + DRAIN_CYCLES;

    // hold keeps rd_ready low for a stretch before this word is taken
    typedef struct packed {
        ft_data_t data;
        ft_be_t   be;
        logic     hold;
    } stim_row_t;

    // byte enables rotate 1111, 0111, 0011, 0001
    stim_row_t rows [N_ROWS] = '{
        {32'h0000_0001, 4'b1111, 1'b0}, {32'hdead_beef, 4'b0111, 1'b0},
        {32'h1234_5678, 4'b0011, 1'b1}, {32'hcafe_f00d, 4'b0001, 1'b0},
        {32'h8000_0000, 4'b1111, 1'b0}, {32'h7fff_ffff, 4'b0111, 1'b0},
        {32'h0f0f_0f0f, 4'b0011, 1'b0}, {32'hf0f0_f0f0, 4'b0001, 1'b0},
        {32'haaaa_5555, 4'b1111, 1'b0}, {32'h5555_aaaa, 4'b0111, 1'b0},
        {32'h0000_ffff, 4'b0011, 1'b0}, {32'hffff_0000, 4'b0001, 1'b0},
        {32'h0bad_c0de, 4'b1111, 1'b0}, {32'h1357_9bdf, 4'b0111, 1'b0},
        {32'h2468_ace0, 4'b0011, 1'b1}, {32'h0000_0000, 4'b0001, 1'b0},
        {32'hffff_ffff, 4'b1111, 1'b0}, {32'h0102_0304, 4'b0111, 1'b0},
        {32'h1122_3344, 4'b0011, 1'b0}, {32'h5566_7788, 4'b0001, 1'b0},
        {32'h99aa_bbcc, 4'b1111, 1'b0}, {32'hddee_ff00, 4'b0111, 1'b0},
        {32'hc001_d00d, 4'b0011, 1'b0}, {32'h7357_0017, 4'b0001, 1'b0}
    };

    logic         clk;
    logic         reset_n;
    user_word_t   wr_word;
    logic         wr_valid;
    logic         wr_ready;
    user_word_t   rd_word;
    logic         rd_valid;
    logic         rd_ready;
    ft_pins_in_t  bus_in;
    ft_pins_out_t bus_out;
    int           model_reads;
    logic         bus_error;
    int           words_taken = 0;

    ft601_bridge i_ft601_bridge (
        .clk      (clk),
        .reset_n  (reset_n),
        .wr_word  (wr_word),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .rd_word  (rd_word),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .bus_in   (bus_in),
        .bus_out  (bus_out)
    );

    ft601_model i_ft601_model (
        .clk        (clk),
        .reset_n    (reset_n),
        .bus_out    (bus_out),
        .bus_in     (bus_in),
        .read_beats (model_reads),
        .bus_error  (bus_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    // called on a falling edge, returns on the falling edge after the handshake
    task automatic send_word(input stim_row_t row);
        wr_word.data = row.data;
        wr_word.be   = row.be;
        wr_valid     = 1'b1;
        while (!wr_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic take_word(input int idx);
        if (rows[idx].hold) begin
            rd_ready = 1'b0;
            repeat (HOLD_CYCLES) @(negedge clk);
        end
        rd_ready = 1'b1;
        while (!rd_valid) begin
            @(negedge clk);
        end
        check_value("rd_word.data", rd_word.data, rows[idx].data);
        check_value("rd_word.be", 32'(rd_word.be), 32'(rows[idx].be));
        words_taken++;
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h88d3));
        reset_n  = 1'b0;
        wr_word  = '0;
        wr_valid = 1'b0;
        rd_ready = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // idle state after reset
        check_value("oe_n", 32'(bus_out.oe_n), 32'd1);
        check_value("rd_n", 32'(bus_out.rd_n), 32'd1);
        check_value("wr_n", 32'(bus_out.wr_n), 32'd1);
        check_value("bus_oe", 32'(bus_out.bus_oe), 32'd0);
        check_value("rd_valid", 32'(rd_valid), 32'd0);
        check_value("wr_ready", 32'(wr_ready), 32'd1);

        fork
            begin
                for (int i = 0; i < N_ROWS; i++) begin
                    send_word(rows[i]);
                end
                wr_valid = 1'b0;
            end
            begin
                for (int j = 0; j < N_ROWS; j++) begin
                    take_word(j);
                end
            end
        join

        // a duplicated word would stay at the output here
        rd_ready = 1'b0;
        repeat (DRAIN_CYCLES) @(negedge clk);
        check_value("rd_valid", 32'(rd_valid), 32'd0);

        if (model_reads == N_ROWS) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("ERR bus_reads: got %h, expected %h", model_reads, N_ROWS);
            abort_run();
        end
    end

    // counters move on falling edges, so they are settled here
    always @(posedge clk) begin
        if (bus_error) begin
            $display("the bus model saw a protocol violation");
            abort_run();
        end else if (model_reads - words_taken > RX_DEPTH) begin
            $display("receive FIFO overrun: %0d words read from the bus, %0d taken by the user",
                     model_reads, words_taken);
            abort_run();
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: loopback did not finish within %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
design/ft_bus_pkg.sv
design/ft_user_pkg.sv
design/sync_fifo.sv
design/ft_bus_ctrl.sv
design/ft601_bridge.sv
test/ft601_model.sv
test/tb_ft601_bridge.sv

//--- run.sh
#!/bin/sh
# builds and runs the FT601 bridge loopback testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_ft601_bridge \
    -f src.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
